//--- verification/spi_stim.txt
# op name value expected, all hex; W and R queue a command word, P pops read data
# S waits for the status to settle, X runs value random commands
S reset_status 0 00a
W wr_reg0 8a5 0
W wr_reg7 f81 0
R rd_reg0 000 0
P pop_reg0 0 1a5
R rd_reg7 700 0
P pop_reg7 0 181
W bp_w1 911 0
W bp_w2 a22 0
W bp_w3 b33 0
W bp_w4 c44 0
W bp_w5 d55 0
W bp_w6 966 0
R bp_r1 100 0
R bp_r2 200 0
R bp_r3 300 0
R bp_r4 400 0
R bp_r5 500 0
S bp_rd_full 0 016
P bp_p1 0 166
P bp_p2 0 122
P bp_p3 0 133
P bp_p4 0 144
P bp_p5 0 155
P bp_empty 0 000
X rand_burst 14 0
S end_status 0 00a

//--- sources.f
+incdir+rtl
rtl/spi_pkg.sv
rtl/sync_fifo.sv
rtl/wb_spi_regs.sv
rtl/spi_sclk_gen.sv
rtl/spi_shifter.sv
rtl/spi_frame_ctrl.sv
rtl/spi_wb_top.sv
verification/spi_slave_model.sv
verification/tb_spi_wb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sources.f --top-module tb_spi_wb

run: compile
	./obj_dir/Vtb_spi_wb | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

//--- verification/tb_spi_wb.sv
`timescale 1ns/100ps
`include "spi_params.svh"

module tb_spi_wb;

  import spi_pkg::*;

  localparam int W = `WB_DATA_WIDTH;

  logic         clk;
  logic         rst_n;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  wb_reg_e      wb_adr;
  logic [W-1:0] wb_dat_i;
  logic [W-1:0] wb_dat_o;
  logic         wb_ack;
  logic         sclk;
  logic         cs;
  logic         mosi;
  logic         miso;
  cmd_t         frame_cmd;
  int           frame_bits;
  int           frames_done;

  string        ops [$];
  string        names [$];
  logic [15:0]  vals [$];
  logic [15:0]  exps [$];
  cmd_t         exp_cmds [$];
  read_t        shadow [8] = '{default: '0};
  logic [15:0]  lfsr = 16'd63;
  int           n_ops = 0;
  int           limit = 0;
  int           cycles = 0;
  int           frames_seen = 0;

  spi_wb_top DUT (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
    .sclk, .cs, .mosi, .miso
  );

  spi_slave_model u_slave (.sclk, .cs, .mosi, .miso, .frame_cmd, .frame_bits, .frames_done);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  task automatic check_read(input string name, input logic exp_v, input read_t exp_b,
                            input logic act_v, input read_t act_b);
    if (exp_v !== act_v || exp_b !== act_b)
      stop_run($sformatf("error %s expected %b/%h actual %b/%h", name, exp_v, exp_b,
                         act_v, act_b));
  endtask

  task automatic check_status(input string name, input logic [4:0] exp, input logic [4:0] act);
    if (exp !== act)
      stop_run($sformatf("error %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_cmd(input string name, input cmd_t exp, input cmd_t act);
    if (exp !== act)
      stop_run($sformatf("error %s expected %h actual %h", name, exp, act));
  endtask

  // Galois LFSR, one step per bit drawn
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  task automatic wb_write(input wb_reg_e adr, input logic [W-1:0] data);
    @(posedge clk);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_i = data;
    do @(negedge clk); while (!wb_ack); // Held off while the command FIFO is full
    @(posedge clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input wb_reg_e adr, output logic [W-1:0] data);
    @(posedge clk);
    #2;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    do @(negedge clk); while (!wb_ack);
    data = wb_dat_o;
    @(posedge clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic read_status(output logic [4:0] st);
    logic [W-1:0] d;
    wb_read(REG_STATUS, d);
    st = d[4:0];
  endtask

  task automatic wait_idle();
    logic [4:0] st;
    do read_status(st); while (st[4] || !st[1]);
  endtask

  task automatic issue_cmd(input cmd_t c);
    exp_cmds.push_back(c);
    if (c.rw)
      shadow[c.addr] = c.data;
    wb_write(REG_CMD, {{(W - `SPI_CMD_WIDTH){1'b0}}, c});
  endtask

  task automatic pop_read(input string name, input logic [8:0] exp);
    logic [4:0]   st;
    logic [W-1:0] d;
    if (exp[8])
    begin
      do read_status(st); while (st[3]); // Byte still on its way
    end
    else
      wait_idle();
    wb_read(REG_RDATA, d);
    check_read(name, exp[8], read_t'(exp[7:0]), d[8], read_t'(d[7:0]));
  endtask

  task automatic run_random(input int count);
    logic [15:0] rw;
    logic [15:0] addr;
    logic [15:0] data;
    cmd_t        c;
    for (int k = 0; k < count; k++)
    begin
      draw_bits(1, rw);
      draw_bits(3, addr);
      draw_bits(8, data);
      c.rw   = rw[0];
      c.addr = addr[2:0];
      c.data = data[7:0];
      issue_cmd(c);
      if (!c.rw)
        pop_read($sformatf("rand_%0d", k), {1'b1, shadow[c.addr]});
    end
  endtask

  task automatic run_op(input string op, input string name, input logic [15:0] val,
                        input logic [15:0] exp);
    logic [4:0] st;
    if (op == "W" || op == "R")
      issue_cmd(cmd_t'(val[11:0]));
    else if (op == "P")
      pop_read(name, exp[8:0]);
    else if (op == "S")
    begin
      for (int i = 0; i < 1000; i++)
      begin
        read_status(st);
        if (st == exp[4:0])
          break;
      end
      check_status(name, exp[4:0], st);
    end
    else if (op == "X")
      run_random(int'(val));
    else
      stop_run($sformatf("unknown operation %s in the stimulus file", op));
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    string       op;
    string       name;
    logic [15:0] val;
    logic [15:0] exp;
    fd = $fopen("verification/spi_stim.txt", "r");
    if (fd == 0)
      stop_run("cannot open verification/spi_stim.txt");
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#")
      begin
        n = $sscanf(line, "%s %s %h %h", op, name, val, exp);
        if (n == 4)
        begin
          ops.push_back(op);
          names.push_back(name);
          vals.push_back(val);
          exps.push_back(exp);
          n_ops += (op == "X") ? int'(val) : 1;
        end
      end
    end
    $fclose(fd);
  endtask

  // Every frame the slave saw must match the next command written
  always @(negedge clk)
  begin
    cmd_t exp_c;
    int   want;
    if (rst_n && frames_done != frames_seen)
    begin
      if (exp_cmds.size() == 0)
        stop_run("the slave saw a frame that was never commanded");
      else
      begin
        exp_c = exp_cmds.pop_front();
        want  = exp_c.rw ? 12 : 20;
        if (frame_bits != want)
          stop_run($sformatf("frame for command %h had %0d sclk edges instead of %0d",
                             exp_c, frame_bits, want));
        else
          check_cmd($sformatf("frame_%0d", frames_seen), exp_c, frame_cmd);
        frames_seen++;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit)
      stop_run($sformatf("the run timed out after %0d clock cycles", cycles));
  end

  initial
  begin
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = REG_CMD;
    wb_dat_i = '0;
    load_stim();
    limit = n_ops * 20 * 2 * `SPI_CLK_DIV * 2;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    if (cs !== 1'b1 || sclk !== 1'b0)
      stop_run($sformatf("error reset_pins expected cs=1 sclk=0 actual cs=%b sclk=%b",
                         cs, sclk));
    for (int i = 0; i < ops.size(); i++)
      run_op(ops[i], names[i], vals[i], exps[i]);
    wait_idle();
    @(negedge clk);
    if (exp_cmds.size() != 0)
      stop_run($sformatf("%0d commands never appeared on the SPI pins", exp_cmds.size()));
    else
    begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

//--- verification/spi_slave_model.sv
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_slave_model (
  input  logic          sclk,
  input  logic          cs,
  input  logic          mosi,
  output logic          miso,
  output spi_pkg::cmd_t frame_cmd,
  output int            frame_bits,
  output int            frames_done
);

  import spi_pkg::*;

  localparam int C_BITS = `SPI_CMD_WIDTH;
  localparam int R_BITS = `SPI_CMD_WIDTH + `SPI_READ_WIDTH;

  read_t             regs [8] = '{default: '0};
  logic [C_BITS-1:0] cmd_sr = '0;
  int                edges = 0;
  int                done_cnt = 0;
  int                last_bits = 0;
  cmd_t              last_cmd = '0;
  logic              miso_bit = 1'b0;
  cmd_t              cur;

  assign cur         = cmd_t'(cmd_sr);
  assign miso        = miso_bit;
  assign frame_cmd   = last_cmd;
  assign frame_bits  = last_bits;
  assign frames_done = done_cnt;

  // Command bits on rising edges, frame results when cs releases
  always @(posedge sclk or posedge cs)
  begin
    if (cs)
    begin
      if (edges != 0)
      begin
        if (cur.rw && edges == C_BITS)
          regs[cur.addr] <= cur.data;
        last_cmd  <= cur;
        last_bits <= edges;
        done_cnt  <= done_cnt + 1;
      end
      edges <= 0;
    end
    else
    begin
      if (edges < C_BITS)
        cmd_sr <= {cmd_sr[C_BITS-2:0], mosi};
      edges <= edges + 1;
    end
  end

  always @(negedge sclk or posedge cs)
  begin
    if (cs)
      miso_bit <= 1'b0;
    else if (!cur.rw && edges >= C_BITS && edges < R_BITS)
      miso_bit <= regs[cur.addr][3'(R_BITS - 1 - edges)]; // MSB first
    else
      miso_bit <= 1'b0;
  end

endmodule

//--- rtl/spi_wb_top.sv
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_wb_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  spi_pkg::wb_reg_e          wb_adr,
  input  logic [`WB_DATA_WIDTH-1:0] wb_dat_i,
  output logic [`WB_DATA_WIDTH-1:0] wb_dat_o,
  output logic                      wb_ack,
  output logic                      sclk,
  output logic                      cs,
  output logic                      mosi,
  input  logic                      miso
);

  import spi_pkg::*;

  cmd_t       cmd_wdata;
  cmd_t       cmd_head;
  read_t      rd_head;
  read_t      rx_byte;
  logic       cmd_push;
  logic       cmd_pop;
  logic       cmd_full;
  logic       cmd_empty;
  logic       rd_push;
  logic       rd_pop;
  logic       rd_full;
  logic       rd_empty;
  logic       busy;
  logic       load;
  logic       sclk_en;
  logic       capture;
  logic       rise_stb;
  logic       fall_stb;
  logic [4:0] bit_cnt;

  wb_spi_regs u_regs (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
    .cmd_push, .cmd_data(cmd_wdata), .cmd_full, .cmd_empty, .rd_full, .rd_empty,
    .busy, .rd_pop, .rd_data(rd_head)
  );

  sync_fifo #(.payload_t(cmd_t), .DEPTH(`FIFO_DEPTH)) u_cmd_fifo (
    .clk, .rst_n, .push(cmd_push), .push_data(cmd_wdata), .full(cmd_full),
    .pop(cmd_pop), .pop_data(cmd_head), .empty(cmd_empty)
  );

  sync_fifo #(.payload_t(read_t), .DEPTH(`FIFO_DEPTH)) u_rd_fifo (
    .clk, .rst_n, .push(rd_push), .push_data(rx_byte), .full(rd_full),
    .pop(rd_pop), .pop_data(rd_head), .empty(rd_empty)
  );

  spi_sclk_gen u_sclk (.clk, .rst_n, .sclk_en, .sclk, .rise_stb, .fall_stb);

  // Shifter loads straight from the FIFO head at the pop
  spi_shifter u_shift (
    .clk, .rst_n, .load, .load_word(cmd_head), .fall_stb, .rise_stb, .capture,
    .miso, .mosi, .bit_cnt, .rx_byte
  );

  spi_frame_ctrl u_frame (
    .clk, .rst_n, .cmd_empty, .cmd_head, .cmd_pop, .rd_full, .rd_push, .load,
    .sclk_en, .capture, .rise_stb, .fall_stb, .bit_cnt, .cs, .busy
  );

endmodule

//--- rtl/spi_frame_ctrl.sv
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_frame_ctrl (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          cmd_empty,
  input  spi_pkg::cmd_t cmd_head,
  output logic          cmd_pop,
  input  logic          rd_full,
  output logic          rd_push,
  output logic          load,
  output logic          sclk_en,
  output logic          capture,
  input  logic          rise_stb,
  input  logic          fall_stb,
  input  logic [4:0]    bit_cnt,
  output logic          cs,
  output logic          busy
);

  import spi_pkg::*;

  localparam int HALF   = `SPI_CLK_DIV;
  localparam int WW     = $clog2(2 * HALF + 1);
  localparam int W_BITS = `SPI_CMD_WIDTH;
  localparam int R_BITS = `SPI_CMD_WIDTH + `SPI_READ_WIDTH;

  typedef enum logic [3:0] {
    IDLE, JUDGE, W_START, W_DATA, W_FINISH, R_START, WR_DATA, RR_DATA, R_FINISH
  } state_e;

  state_e        state;
  state_e        state_nx;
  logic          cur_rw;
  logic [WW-1:0] wait_cnt;
  logic          in_finish;
  logic          finish_done;

  assign in_finish   = (state == W_FINISH) || (state == R_FINISH);
  assign finish_done = (wait_cnt == WW'(2 * HALF - 1)); // cs low half, then cs high half

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      cur_rw   <= 1'b0;
      wait_cnt <= '0;
    end
    else
    begin
      state <= state_nx;
      if (cmd_pop)
        cur_rw <= cmd_head.rw; // Head moves on after the pop
      wait_cnt <= in_finish ? wait_cnt + 1'b1 : '0;
    end
  end

  always_comb
  begin
    state_nx = state;
    case (state)
      IDLE:     if (!cmd_empty) state_nx = JUDGE;
      JUDGE:
      begin
        if (cur_rw)
          state_nx = W_START;
        else if (!rd_full)
          state_nx = R_START; // Room must exist for the byte
      end
      W_START:  if (rise_stb) state_nx = W_DATA;
      W_DATA:   if (bit_cnt == 5'(W_BITS) && fall_stb) state_nx = W_FINISH;
      W_FINISH: if (finish_done) state_nx = IDLE;
      R_START:  if (rise_stb) state_nx = WR_DATA;
      WR_DATA:  if (bit_cnt == 5'(W_BITS)) state_nx = RR_DATA;
      RR_DATA:  if (bit_cnt == 5'(R_BITS) && fall_stb) state_nx = R_FINISH;
      R_FINISH: if (finish_done) state_nx = IDLE;
      default:  state_nx = IDLE;
    endcase
  end

  assign cmd_pop = (state == IDLE) && !cmd_empty;
  assign load    = cmd_pop;
  assign sclk_en = (state == W_START) || (state == W_DATA) || (state == R_START) ||
                   (state == WR_DATA) || (state == RR_DATA);
  assign capture = (state == RR_DATA);
  assign busy    = (state != IDLE);

  // cs is released one half period into the finish state
  assign cs      = (state == IDLE) || (state == JUDGE) ||
                   (in_finish && (wait_cnt >= WW'(HALF)));
  assign rd_push = (state == R_FINISH) && (wait_cnt == WW'(HALF + 1));

  // Bit count never runs past the phase being clocked
  a_cnt_in_data: assert property (@(posedge clk) disable iff (!rst_n)
                                  (state inside {W_DATA, WR_DATA, RR_DATA}) |->
                                  (bit_cnt <= ((state == RR_DATA) ? 5'(R_BITS) : 5'(W_BITS))))
    else $error("bit count overrun in a data state");

endmodule

//--- rtl/spi_shifter.sv
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_shifter (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load,
  input  spi_pkg::cmd_t  load_word,
  input  logic           fall_stb,
  input  logic           rise_stb,
  input  logic           capture,
  input  logic           miso,
  output logic           mosi,
  output logic [4:0]     bit_cnt,
  output spi_pkg::read_t rx_byte
);

  import spi_pkg::*;

  logic [`SPI_CMD_WIDTH-1:0] shift_reg;

  assign mosi = shift_reg[`SPI_CMD_WIDTH-1]; // MSB first

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_reg <= '0;
      bit_cnt   <= '0;
    end
    else if (load)
    begin
      shift_reg <= load_word;
      bit_cnt   <= '0;
    end
    else
    begin
      // Zeros follow the command so mosi idles low in the read phase
      if (fall_stb && (bit_cnt != '0))
        shift_reg <= {shift_reg[`SPI_CMD_WIDTH-2:0], 1'b0};
      if (rise_stb)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      rx_byte <= '0;
    end
    else if (rise_stb && capture)
    begin
      rx_byte <= {rx_byte[`SPI_READ_WIDTH-2:0], miso};
    end
  end

endmodule

//--- rtl/spi_sclk_gen.sv
`timescale 1ns/100ps
`include "spi_params.svh"

module spi_sclk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk_en,
  output logic sclk,
  output logic rise_stb,
  output logic fall_stb
);

  localparam int DIV = `SPI_CLK_DIV;
  localparam int CW  = $clog2(DIV + 1);

  logic [CW-1:0] cnt;
  logic          half_done;

  assign half_done = sclk_en && (cnt == CW'(DIV - 1));

  // Strobes mark the clk edge at which sclk toggles
  assign rise_stb = half_done && !sclk;
  assign fall_stb = half_done && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt  <= '0;
      sclk <= 1'b0;
    end
    else if (!sclk_en)
    begin
      cnt  <= '0;  // Restart the half period for the next frame
      sclk <= 1'b0;
    end
    else if (half_done)
    begin
      cnt  <= '0;
      sclk <= ~sclk;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  a_sclk_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                                 !$past(sclk_en) |-> $stable(sclk))
    else $error("sclk moved while disabled");

endmodule

//--- rtl/wb_spi_regs.sv
`timescale 1ns/100ps
`include "spi_params.svh"

module wb_spi_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  spi_pkg::wb_reg_e          wb_adr,
  input  logic [`WB_DATA_WIDTH-1:0] wb_dat_i,
  output logic [`WB_DATA_WIDTH-1:0] wb_dat_o,
  output logic                      wb_ack,
  output logic                      cmd_push,
  output spi_pkg::cmd_t             cmd_data,
  input  logic                      cmd_full,
  input  logic                      cmd_empty,
  input  logic                      rd_full,
  input  logic                      rd_empty,
  input  logic                      busy,
  output logic                      rd_pop,
  input  spi_pkg::read_t            rd_data
);

  import spi_pkg::*;

  localparam int W = `WB_DATA_WIDTH;

  logic         req;
  logic         cmd_wr;
  logic         rdata_rd;
  logic [W-1:0] status_word;
  logic [W-1:0] rdata_word;

  // A new access is one that has not been acked yet
  assign req      = wb_cyc && wb_stb && !wb_ack;
  assign cmd_wr   = req && wb_we && (wb_adr == REG_CMD);
  assign rdata_rd = req && !wb_we && (wb_adr == REG_RDATA);

  assign cmd_push = cmd_wr && !cmd_full; // Held off while full
  assign cmd_data = cmd_t'(wb_dat_i[$bits(cmd_t)-1:0]);
  assign rd_pop   = rdata_rd && !rd_empty;

  assign status_word = {{(W-5){1'b0}}, busy, rd_empty, rd_full, cmd_empty, cmd_full};
  assign rdata_word  = {{(W-$bits(read_t)-1){1'b0}}, !rd_empty,
                        rd_empty ? read_t'(0) : rd_data};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wb_ack <= 1'b0;
    else
      wb_ack <= req && !(cmd_wr && cmd_full);
  end

  always_ff @(posedge clk)
  begin
    if (req && !wb_we)
    begin
      case (wb_adr)
        REG_STATUS: wb_dat_o <= status_word;
        REG_RDATA:  wb_dat_o <= rdata_word; // Sampled at the same edge as the pop
        default:    wb_dat_o <= '0;
      endcase
    end
  end

  // Master holds cyc and stb until it sees ack
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                                   wb_ack |-> wb_cyc && wb_stb)
    else $error("wb_ack outside an active bus cycle");

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_push;
  logic            do_pop;

  assign full     = (count == CW'(DEPTH));
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr]; // Head is visible before the pop
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producers and consumers must respect full and empty
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("sync_fifo push while full");
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("sync_fifo pop while empty");

endmodule

//--- rtl/spi_pkg.sv
`include "spi_params.svh"

package spi_pkg;

  // Command word as seen on mosi, rw is sent first
  typedef struct packed {
    logic                        rw;   // 1 = write, 0 = read
    logic [2:0]                  addr;
    logic [`SPI_CMD_WIDTH-5:0]   data;
  } cmd_t;

  typedef logic [`SPI_READ_WIDTH-1:0] read_t;

  // Wishbone register map
  typedef enum logic [1:0] {
    REG_CMD    = 2'd0,
    REG_STATUS = 2'd1,
    REG_RDATA  = 2'd2
  } wb_reg_e;

endpackage

//--- rtl/spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// SPI frame widths
`define SPI_CMD_WIDTH 12
`define SPI_READ_WIDTH 8

// clk cycles per SCLK half period
`define SPI_CLK_DIV 4

// Entries in each of the command and read FIFOs
`define FIFO_DEPTH 4

`define WB_DATA_WIDTH 16

`endif
